/* hw/mem_bridge_pkg.sv */
package mem_bridge_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int BEAT_W     = 3;                      // log2 of LINE_WORDS
    localparam int LINE_OFS_W = 5;                      // byte offset bits inside a line
    localparam int AXI_LEN_W  = 4;

    localparam logic [2:0]          AXI_SIZE_WORD  = 3'b010;   // 4 bytes per beat
    localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
    localparam logic [DATA_W/8-1:0] STRB_ALL       = '1;

    // word 0 sits at the line address
    typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,                                        // aw phase
        WB_DATA,                                        // w beats
        WB_RESP                                         // waiting on b
    } wbuf_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    typedef enum logic {
        OWN_INST,
        OWN_DATA
    } rd_owner_e;

endpackage

/* hw/wbuf_line_store.sv */
`timescale 1ns/100ps

module wbuf_line_store
    import mem_bridge_pkg::*;
(
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              load_i,
    input  logic [ADDR_W-1:0] paddr_i,
    input  line_t             line_i,
    input  logic              drain_done_i,
    input  logic [ADDR_W-1:0] lookup_paddr_i,
    input  logic [BEAT_W-1:0] beat_idx_i,
    output logic              empty_o,
    output logic              lookup_hit_o,
    output line_t             lookup_data_o,
    output logic [ADDR_W-1:0] line_addr_o,
    output logic [DATA_W-1:0] beat_word_o
);

    logic                         valid_q;
    logic [ADDR_W-LINE_OFS_W-1:0] tag_q;      // line-aligned address bits
    line_t                        line_q;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (drain_done_i) begin
            valid_q <= 1'b0;                  // released on the b transfer
        end
    end

    always_ff @(posedge aclk) begin
        if (load_i) begin
            tag_q  <= paddr_i[ADDR_W-1:LINE_OFS_W];
            line_q <= line_i;
        end
    end

    assign empty_o = ~valid_q;

    // lookup is same-cycle, only the bits above the line offset count
    assign lookup_hit_o  = valid_q && (lookup_paddr_i[ADDR_W-1:LINE_OFS_W] == tag_q);
    assign lookup_data_o = line_q;

    assign line_addr_o = {tag_q, {LINE_OFS_W{1'b0}}};
    assign beat_word_o = line_q[beat_idx_i];  // word for the current w beat

endmodule

/* hw/beat_counter.sv */
`timescale 1ns/100ps

module beat_counter
    import mem_bridge_pkg::*;
(
    input  logic              aclk,
    input  logic              rst_n_i,
    input  logic              clear_i,
    input  logic              advance_i,
    output logic [BEAT_W-1:0] beat_idx_o,
    output logic              last_beat_o
);

    logic [BEAT_W-1:0] beat_q;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            beat_q <= '0;
        end else if (clear_i) begin
            beat_q <= '0;                     // start of a new burst
        end else if (advance_i) begin
            beat_q <= beat_q + 1'b1;          // one step per w transfer
        end
    end

    assign beat_idx_o  = beat_q;
    assign last_beat_o = (beat_q == BEAT_W'(LINE_WORDS - 1));

endmodule

/* hw/wbuf_drain_fsm.sv */
`timescale 1ns/100ps

module wbuf_drain_fsm
    import mem_bridge_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n_i,
    input  logic                 wreq_i,
    input  logic                 awready_i,
    input  logic                 wready_i,
    input  logic                 bvalid_i,
    input  logic                 last_beat_i,
    output logic                 load_o,
    output logic                 drain_done_o,
    output logic                 beat_clear_o,
    output logic                 beat_advance_o,
    output logic                 awvalid_o,
    output logic                 wvalid_o,
    output logic                 wlast_o,
    output logic                 bready_o,
    output logic [AXI_LEN_W-1:0] awlen_o,
    output logic [2:0]           awsize_o,
    output logic [1:0]           awburst_o
);

    wbuf_state_e state_q;
    wbuf_state_e state_d;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        load_o         = 1'b0;
        drain_done_o   = 1'b0;
        beat_clear_o   = 1'b0;
        beat_advance_o = 1'b0;
        case (state_q)
            WB_IDLE: begin
                load_o = wreq_i;                             // only taken when empty
                if (wreq_i) state_d = WB_ADDR;
            end
            WB_ADDR: begin
                beat_clear_o = awready_i;                    // counter at 0 on entry to data
                if (awready_i) state_d = WB_DATA;
            end
            WB_DATA: begin
                beat_advance_o = wready_i;
                if (wready_i && last_beat_i) state_d = WB_RESP;
            end
            WB_RESP: begin
                drain_done_o = bvalid_i;
                if (bvalid_i) state_d = WB_IDLE;
            end
            default: state_d = WB_IDLE;
        endcase
    end

    assign awvalid_o = (state_q == WB_ADDR);
    assign wvalid_o  = (state_q == WB_DATA);
    assign wlast_o   = (state_q == WB_DATA) && last_beat_i;
    assign bready_o  = (state_q == WB_RESP);

    // always a full line burst
    assign awlen_o   = AXI_LEN_W'(LINE_WORDS - 1);
    assign awsize_o  = AXI_SIZE_WORD;
    assign awburst_o = AXI_BURST_INCR;

endmodule

/* hw/rd_arbiter.sv */
`timescale 1ns/100ps

module rd_arbiter
    import mem_bridge_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n_i,
    input  logic                 inst_arvalid_i,
    input  logic [ADDR_W-1:0]    inst_araddr_i,
    input  logic [AXI_LEN_W-1:0] inst_arlen_i,
    input  logic                 inst_rready_i,
    output logic                 inst_arready_o,
    output logic [DATA_W-1:0]    inst_rdata_o,
    output logic                 inst_rvalid_o,
    output logic                 inst_rlast_o,
    input  logic                 data_arvalid_i,
    input  logic [ADDR_W-1:0]    data_araddr_i,
    input  logic [AXI_LEN_W-1:0] data_arlen_i,
    input  logic                 data_rready_i,
    output logic                 data_arready_o,
    output logic [DATA_W-1:0]    data_rdata_o,
    output logic                 data_rvalid_o,
    output logic                 data_rlast_o,
    output logic [ADDR_W-1:0]    araddr_o,
    output logic [AXI_LEN_W-1:0] arlen_o,
    output logic [2:0]           arsize_o,
    output logic [1:0]           arburst_o,
    output logic                 arvalid_o,
    output logic                 rready_o,
    input  logic                 arready_i,
    input  logic [DATA_W-1:0]    rdata_i,
    input  logic                 rvalid_i,
    input  logic                 rlast_i
);

    rd_state_e            state_q;
    rd_owner_e            owner_q;
    logic [ADDR_W-1:0]    addr_q;
    logic [AXI_LEN_W-1:0] len_q;
    logic                 idle;
    logic                 in_data;
    logic                 grant;

    assign idle    = (state_q == RD_IDLE);
    assign in_data = (state_q == RD_DATA);
    assign grant   = idle && (inst_arvalid_i || data_arvalid_i);

    // data side has priority
    assign data_arready_o = idle && data_arvalid_i;
    assign inst_arready_o = idle && inst_arvalid_i && !data_arvalid_i;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            state_q <= RD_IDLE;
            owner_q <= OWN_INST;
        end else begin
            case (state_q)
                RD_IDLE: if (grant) begin
                    state_q <= RD_ADDR;
                    owner_q <= data_arvalid_i ? OWN_DATA : OWN_INST;
                end
                RD_ADDR: if (arready_i) state_q <= RD_DATA;
                RD_DATA: if (rvalid_i && rready_o && rlast_i) state_q <= RD_IDLE;
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (grant) begin
            addr_q <= data_arvalid_i ? data_araddr_i : inst_araddr_i;
            len_q  <= data_arvalid_i ? data_arlen_i : inst_arlen_i;
        end
    end

    assign araddr_o  = addr_q;
    assign arlen_o   = len_q;
    assign arsize_o  = AXI_SIZE_WORD;
    assign arburst_o = AXI_BURST_INCR;
    assign arvalid_o = (state_q == RD_ADDR);

    // r channel steered to the owner only
    assign rready_o      = in_data && ((owner_q == OWN_DATA) ? data_rready_i : inst_rready_i);
    assign inst_rvalid_o = in_data && (owner_q == OWN_INST) && rvalid_i;
    assign data_rvalid_o = in_data && (owner_q == OWN_DATA) && rvalid_i;
    assign inst_rlast_o  = in_data && (owner_q == OWN_INST) && rlast_i;
    assign data_rlast_o  = in_data && (owner_q == OWN_DATA) && rlast_i;
    assign inst_rdata_o  = rdata_i;
    assign data_rdata_o  = rdata_i;

endmodule

/* hw/mem_bridge_top.sv */
`timescale 1ns/100ps

module mem_bridge_top
    import mem_bridge_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst_n_i,
    // data cache write side
    input  logic                 wreq_i,
    input  logic [ADDR_W-1:0]    wreq_paddr_i,
    input  line_t                wreq_line_i,
    input  logic [ADDR_W-1:0]    lookup_paddr_i,
    output logic                 wreq_recvd_o,
    output logic                 empty_o,
    output logic                 lookup_hit_o,
    output line_t                lookup_data_o,
    // axi write
    output logic [ADDR_W-1:0]    awaddr_o,
    output logic [AXI_LEN_W-1:0] awlen_o,
    output logic [2:0]           awsize_o,
    output logic [1:0]           awburst_o,
    output logic                 awvalid_o,
    input  logic                 awready_i,
    output logic [DATA_W-1:0]    wdata_o,
    output logic [DATA_W/8-1:0]  wstrb_o,
    output logic                 wlast_o,
    output logic                 wvalid_o,
    input  logic                 wready_i,
    input  logic                 bvalid_i,
    output logic                 bready_o,
    // read masters
    input  logic                 inst_arvalid_i,
    input  logic [ADDR_W-1:0]    inst_araddr_i,
    input  logic [AXI_LEN_W-1:0] inst_arlen_i,
    input  logic                 inst_rready_i,
    output logic                 inst_arready_o,
    output logic [DATA_W-1:0]    inst_rdata_o,
    output logic                 inst_rvalid_o,
    output logic                 inst_rlast_o,
    input  logic                 data_arvalid_i,
    input  logic [ADDR_W-1:0]    data_araddr_i,
    input  logic [AXI_LEN_W-1:0] data_arlen_i,
    input  logic                 data_rready_i,
    output logic                 data_arready_o,
    output logic [DATA_W-1:0]    data_rdata_o,
    output logic                 data_rvalid_o,
    output logic                 data_rlast_o,
    // axi read
    output logic [ADDR_W-1:0]    araddr_o,
    output logic [AXI_LEN_W-1:0] arlen_o,
    output logic [2:0]           arsize_o,
    output logic [1:0]           arburst_o,
    output logic                 arvalid_o,
    output logic                 rready_o,
    input  logic                 arready_i,
    input  logic [DATA_W-1:0]    rdata_i,
    input  logic                 rvalid_i,
    input  logic                 rlast_i
);

    logic              drain_done;
    logic              beat_clear;
    logic              beat_advance;
    logic [BEAT_W-1:0] beat_idx;
    logic              last_beat;

    assign wstrb_o = STRB_ALL;                // full words only

    wbuf_line_store i_line_store (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .load_i         (wreq_recvd_o),       // the accept pulse loads the line
        .paddr_i        (wreq_paddr_i),
        .line_i         (wreq_line_i),
        .drain_done_i   (drain_done),
        .lookup_paddr_i (lookup_paddr_i),
        .beat_idx_i     (beat_idx),
        .empty_o        (empty_o),
        .lookup_hit_o   (lookup_hit_o),
        .lookup_data_o  (lookup_data_o),
        .line_addr_o    (awaddr_o),
        .beat_word_o    (wdata_o)
    );

    beat_counter i_beat_counter (
        .aclk        (aclk),
        .rst_n_i     (rst_n_i),
        .clear_i     (beat_clear),
        .advance_i   (beat_advance),
        .beat_idx_o  (beat_idx),
        .last_beat_o (last_beat)
    );

    wbuf_drain_fsm i_drain_fsm (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .wreq_i         (wreq_i),
        .awready_i      (awready_i),
        .wready_i       (wready_i),
        .bvalid_i       (bvalid_i),
        .last_beat_i    (last_beat),
        .load_o         (wreq_recvd_o),
        .drain_done_o   (drain_done),
        .beat_clear_o   (beat_clear),
        .beat_advance_o (beat_advance),
        .awvalid_o      (awvalid_o),
        .wvalid_o       (wvalid_o),
        .wlast_o        (wlast_o),
        .bready_o       (bready_o),
        .awlen_o        (awlen_o),
        .awsize_o       (awsize_o),
        .awburst_o      (awburst_o)
    );

    rd_arbiter i_rd_arbiter (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .inst_arvalid_i (inst_arvalid_i),
        .inst_araddr_i  (inst_araddr_i),
        .inst_arlen_i   (inst_arlen_i),
        .inst_rready_i  (inst_rready_i),
        .inst_arready_o (inst_arready_o),
        .inst_rdata_o   (inst_rdata_o),
        .inst_rvalid_o  (inst_rvalid_o),
        .inst_rlast_o   (inst_rlast_o),
        .data_arvalid_i (data_arvalid_i),
        .data_araddr_i  (data_araddr_i),
        .data_arlen_i   (data_arlen_i),
        .data_rready_i  (data_rready_i),
        .data_arready_o (data_arready_o),
        .data_rdata_o   (data_rdata_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rlast_o   (data_rlast_o),
        .araddr_o       (araddr_o),
        .arlen_o        (arlen_o),
        .arsize_o       (arsize_o),
        .arburst_o      (arburst_o),
        .arvalid_o      (arvalid_o),
        .rready_o       (rready_o),
        .arready_i      (arready_i),
        .rdata_i        (rdata_i),
        .rvalid_i       (rvalid_i),
        .rlast_i        (rlast_i)
    );

endmodule

/* dv/mem_bridge_sva.sv */
`timescale 1ns/100ps

module mem_bridge_sva
    import mem_bridge_pkg::*;
(
    input logic              aclk,
    input logic              rst_n_i,
    input logic              awvalid_i,
    input logic              awready_i,
    input logic [ADDR_W-1:0] awaddr_i,
    input logic              wvalid_i,
    input logic              wready_i,
    input logic              wlast_i,
    input logic              inst_rvalid_i,
    input logic              data_rvalid_i
);

    int fail_cnt;                             // count of failed assertions

    initial fail_cnt = 0;

    a_aw_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            fail_cnt++;
            $error("awvalid or awaddr changed before awready");
        end

    a_w_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
        wvalid_i && !wready_i |=> wvalid_i)
        else begin
            fail_cnt++;
            $error("wvalid dropped before wready");
        end

    a_wlast_valid: assert property (@(posedge aclk) disable iff (!rst_n_i) wlast_i |-> wvalid_i)
        else begin
            fail_cnt++;
            $error("wlast high without wvalid");
        end

    // r data goes to one side only
    a_r_one_side: assert property (@(posedge aclk) disable iff (!rst_n_i)
        !(inst_rvalid_i && data_rvalid_i))
        else begin
            fail_cnt++;
            $error("inst and data rvalid high together");
        end

endmodule

/* dv/mem_bridge_tb.sv */
`timescale 1ns/100ps

module mem_bridge_tb
    import mem_bridge_pkg::*;
();

    logic                 aclk, rst_n_i, wreq_i, wreq_recvd_o, empty_o, lookup_hit_o;
    logic [ADDR_W-1:0]    wreq_paddr_i, lookup_paddr_i, awaddr_o, araddr_o;
    logic [ADDR_W-1:0]    inst_araddr_i, data_araddr_i;
    line_t                wreq_line_i, lookup_data_o;
    logic [AXI_LEN_W-1:0] awlen_o, arlen_o, inst_arlen_i, data_arlen_i;
    logic [2:0]           awsize_o, arsize_o;
    logic [1:0]           awburst_o, arburst_o;
    logic [DATA_W-1:0]    wdata_o, rdata_i, inst_rdata_o, data_rdata_o;
    logic [DATA_W/8-1:0]  wstrb_o;
    logic awvalid_o, awready_i, wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;
    logic inst_arvalid_i, inst_rready_i, inst_arready_o, inst_rvalid_o, inst_rlast_o;
    logic data_arvalid_i, data_rready_i, data_arready_o, data_rvalid_o, data_rlast_o;
    logic arvalid_o, rready_o, arready_i, rvalid_i, rlast_i;

    int                   err_cnt, chk_cnt, w_beat, r_beat;
    logic aw_hold, b_pending, b_done, r_active, r_fired, inst_busy, data_busy;
    logic [ADDR_W-1:0]    exp_addr, r_addr;
    logic [AXI_LEN_W-1:0] r_len;
    line_t                exp_line;
    logic [ADDR_W-1:0]    exp_ar [$];            // araddr values in grant order
    logic                 pend [2];              // index 0 inst, 1 data
    logic [ADDR_W-1:0]    pend_addr [2];
    int                   pend_len [2];
    byte                  op_kind [$];
    byte                  op_side [$];
    logic [ADDR_W-1:0]    op_addr [$];
    int                   op_num [$];            // hit flag or burst length
    line_t                op_line [$];

    mem_bridge_top i_dut (.*);

    bind mem_bridge_top mem_bridge_sva i_sva (
        .aclk (aclk), .rst_n_i (rst_n_i), .awvalid_i (awvalid_o), .awready_i (awready_i),
        .awaddr_i (awaddr_o), .wvalid_i (wvalid_o), .wready_i (wready_i), .wlast_i (wlast_o),
        .inst_rvalid_i (inst_rvalid_o), .data_rvalid_i (data_rvalid_o)
    );

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic run_watchdog(input int n_ops);
        repeat ((n_ops + 1) * 300) @(posedge aclk);
        $display("Timeout: the run did not end within %0d cycles", (n_ops + 1) * 300);
        $display("TEST FAIL");
        $finish;
    endtask

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // axi slave model with random stalls
    initial begin
        void'($urandom(68605));
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rlast_i   = 1'b0;
        rdata_i   = '0;
        @(posedge aclk);                          // skip the x to 0 step of the clock
        forever begin
            @(negedge aclk);
            awready_i = !aw_hold && ($urandom % 4 != 0);
            wready_i  = ($urandom % 4 != 0);
            bvalid_i  = b_pending && (bvalid_i || ($urandom % 2 == 0));
            arready_i = ($urandom % 3 != 0);
            if (!rvalid_i || r_fired) begin       // a pending beat stays put
                rvalid_i = r_active && ($urandom % 4 != 0);
                rdata_i  = ~(r_addr + 32'(4 * r_beat));
                rlast_i  = r_active && (r_beat == int'(r_len));
            end
            r_fired = 1'b0;
        end
    end

    always @(posedge aclk) begin
        if (rst_n_i) begin
            if (b_done) compare("empty after b", 1, empty_o);
            b_done = 1'b0;
            if (wreq_recvd_o && !empty_o) begin
                err_cnt++;
                $display("Error: a line was accepted while the buffer still held one");
            end
            if (awvalid_o && awready_i) begin
                compare("awaddr", exp_addr, awaddr_o);
                compare("awlen", 7, awlen_o);
                compare("awsize", 2, awsize_o);
                compare("awburst", 1, awburst_o);
                w_beat = 0;
            end
            if (wvalid_o && wready_i) begin
                compare("wdata", exp_line[w_beat], wdata_o);
                compare("wstrb", 4'hf, wstrb_o);
                compare("wlast", w_beat == 7, wlast_o);
                w_beat++;
                if (wlast_o) b_pending = 1'b1;
            end
            if (bvalid_i && bready_o) begin
                compare("w beats", 8, w_beat);
                b_pending = 1'b0;
                b_done    = 1'b1;
            end
            if (arvalid_o && arready_i) begin
                if (exp_ar.size() == 0) begin
                    err_cnt++;
                    $display("Error: a read address was issued with no read pending");
                end else begin
                    compare("araddr", exp_ar.pop_front(), araddr_o);
                end
                compare("arsize", 2, arsize_o);
                compare("arburst", 1, arburst_o);
                r_active = 1'b1;
                r_addr   = araddr_o;
                r_len    = arlen_o;
                r_beat   = 0;
            end
            if (rvalid_i && rready_o) begin
                r_beat++;
                r_fired = 1'b1;
                if (rlast_i) r_active = 1'b0;
            end
            if ((inst_rvalid_o && !inst_busy) || (data_rvalid_o && !data_busy)) begin
                err_cnt++;
                $display("Error: read data showed up on a port with no read in flight");
            end
        end
    end

    task automatic read_burst(input bit is_data, input logic [ADDR_W-1:0] addr, input int len);
        int k;
        k = 0;
        @(negedge aclk);
        if (is_data) begin
            data_busy      = 1'b1;
            data_arvalid_i = 1'b1;
            data_araddr_i  = addr;
            data_arlen_i   = AXI_LEN_W'(len);
        end else begin
            inst_busy      = 1'b1;
            inst_arvalid_i = 1'b1;
            inst_araddr_i  = addr;
            inst_arlen_i   = AXI_LEN_W'(len);
        end
        do @(posedge aclk); while (!(is_data ? data_arready_o : inst_arready_o));
        @(negedge aclk);
        if (is_data) data_arvalid_i = 1'b0;
        else inst_arvalid_i = 1'b0;
        forever begin
            @(posedge aclk);
            if (is_data ? data_rvalid_o : inst_rvalid_o) begin
                compare("rdata", ~(addr + 32'(4 * k)), is_data ? data_rdata_o : inst_rdata_o);
                compare("rlast", k == len, is_data ? data_rlast_o : inst_rlast_o);
                k++;
                if (is_data ? data_rlast_o : inst_rlast_o) break;
            end
        end
        @(negedge aclk);
        if (is_data) data_busy = 1'b0;
        else inst_busy = 1'b0;
    endtask

    task automatic flush_reads();
        if (pend[1]) exp_ar.push_back(pend_addr[1]);   // data wins when both ask
        if (pend[0]) exp_ar.push_back(pend_addr[0]);
        fork
            if (pend[1]) read_burst(1'b1, pend_addr[1], pend_len[1]);
            if (pend[0]) read_burst(1'b0, pend_addr[0], pend_len[0]);
        join
        pend[0] = 1'b0;
        pend[1] = 1'b0;
    endtask

    task automatic drain_line();
        aw_hold = 1'b0;
        while (!empty_o) @(posedge aclk);
    endtask

    task automatic write_line(input logic [ADDR_W-1:0] addr, input line_t line);
        int stall;
        stall = 0;
        @(negedge aclk);
        wreq_i       = 1'b1;
        wreq_paddr_i = addr;
        wreq_line_i  = line;
        do begin
            @(posedge aclk);
            stall++;
            if (stall == 6) aw_hold = 1'b0;   // let a held line go out
        end while (!wreq_recvd_o);
        exp_addr = addr & ~32'h1f;            // 32 byte lines
        exp_line = line;
        aw_hold  = 1'b1;                      // keep the new line in the buffer
        @(negedge aclk);
        wreq_i = 1'b0;
    endtask

    task automatic lookup_line(input logic [ADDR_W-1:0] addr, input int hit, input line_t line);
        int k;
        @(negedge aclk);
        lookup_paddr_i = addr;
        @(posedge aclk);
        compare("lookup hit", hit, lookup_hit_o);
        if (hit) begin
            for (k = 0; k < LINE_WORDS; k++) compare("lookup word", line[k], lookup_data_o[k]);
        end
    endtask

    initial begin
        int                fd, n, need, c, hit, len, i, k, s;
        byte               kind, side;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] w [LINE_WORDS];
        line_t             line;
        rst_n_i = 1'b0;
        wreq_i = 1'b0;
        wreq_paddr_i = '0;
        wreq_line_i = '0;
        lookup_paddr_i = '0;
        inst_arvalid_i = 1'b0;
        inst_araddr_i = '0;
        inst_arlen_i = '0;
        inst_rready_i = 1'b1;
        data_arvalid_i = 1'b0;
        data_araddr_i = '0;
        data_arlen_i = '0;
        data_rready_i = 1'b1;
        {aw_hold, b_pending, b_done, r_active, r_fired, inst_busy, data_busy} = 7'b1000000;
        {err_cnt, chk_cnt, w_beat, r_beat} = '0;
        r_addr = '0;
        r_len = '0;
        pend[0] = 1'b0;
        pend[1] = 1'b0;
        fd = $fopen("dv/mem_bridge_patterns.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("Error: the pattern file could not be opened");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                side = "-";
                hit  = 0;
                len  = 0;
                if (kind == "#") begin
                    do c = $fgetc(fd); while (c != "\n" && c != -1);
                    continue;
                end else if (kind == "W") begin
                    need = 9;
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", addr,
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                end else if (kind == "L") begin
                    need = 10;
                    n = $fscanf(fd, "%h %d %h %h %h %h %h %h %h %h", addr, hit,
                                w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                end else begin
                    need = 3;
                    n = $fscanf(fd, " %c %h %d", side, addr, len);
                end
                if (n != need) begin
                    err_cnt++;
                    $display("Error: a pattern line of kind %c is malformed", kind);
                end
                for (k = 0; k < LINE_WORDS; k++) line[k] = (kind == "R") ? '0 : w[k];
                op_kind.push_back(kind);
                op_side.push_back(side);
                op_addr.push_back(addr);
                op_num.push_back((kind == "R") ? len : hit);
                op_line.push_back(line);
            end
            $fclose(fd);
        end
        fork
            run_watchdog(op_kind.size());
        join_none
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        rst_n_i = 1'b1;
        compare("empty after reset", 1, empty_o);
        compare("outputs after reset", 0, {wreq_recvd_o, awvalid_o, wvalid_o, wlast_o, bready_o,
                arvalid_o, rready_o, inst_arready_o, data_arready_o, inst_rvalid_o, data_rvalid_o});
        for (i = 0; i < op_kind.size(); i++) begin
            if (op_kind[i] != "R") flush_reads();
            case (op_kind[i])
                "W": write_line(op_addr[i], op_line[i]);
                "L": lookup_line(op_addr[i], op_num[i], op_line[i]);
                default: begin
                    s = (op_side[i] == "D") ? 1 : 0;
                    if (pend[s]) flush_reads();
                    drain_line();
                    pend[s]      = 1'b1;
                    pend_addr[s] = op_addr[i];
                    pend_len[s]  = op_num[i];
                end
            endcase
        end
        flush_reads();
        drain_line();
        repeat (4) @(posedge aclk);
        err_cnt += i_dut.i_sva.fail_cnt;
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* dv/mem_bridge_patterns.txt */
# W addr word0..word7 : write one line, its burst is checked as it drains
# L addr hit word0..word7 : lookup with expected hit and words, words unused on a miss
# R side addr len : read burst on side I or D, adjacent I and D lines start together
W 00001048 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
L 00001054 1 a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006 a0000007
L 00002054 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
R I 00008000 3
L 00001054 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
R D 0000a100 7
R I 00000200 1
W 000030e0 c0de0000 c0de1111 c0de2222 c0de3333 c0de4444 c0de5555 c0de6666 c0de7777
L 000030fc 1 c0de0000 c0de1111 c0de2222 c0de3333 c0de4444 c0de5555 c0de6666 c0de7777
W 00004000 d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e d000000f
L 00004010 1 d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e d000000f
L 000030e0 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
R D 00000300 0
R I 00000400 15

/* mem_bridge_top.f */
hw/mem_bridge_pkg.sv
hw/wbuf_line_store.sv
hw/beat_counter.sv
hw/wbuf_drain_fsm.sv
hw/rd_arbiter.sv
hw/mem_bridge_top.sv
dv/mem_bridge_sva.sv
dv/mem_bridge_tb.sv
